// ==== ucodePkg.sv ====
package ucodePkg;

	////////////////////////////////////////
	// Basic widths
	////////////////////////////////////////

	// Opcode or CB suffix byte
	typedef logic [7:0] opcodeT;

	// ROM address and flow start index
	typedef logic [8:0] flowIdxT;

	// Words actually populated in the ROM
	localparam int RomDepth = 95;

	////////////////////////////////////////
	// Micro-op fields
	////////////////////////////////////////

	// How a micro-op steps the flow
	typedef enum logic [3:0] {
		ctlOp,
		ctlInc,
		ctlEof,
		ctlIncEof,
		ctlEofFu,
		ctlIncEofFu,
		ctlUpdFlags,
		ctlIncEofZ,
		ctlIncEofNz
	} uopCtlT;

	// Datapath operation
	typedef enum logic [4:0] {
		opNop,
		opSma,
		opSmw,
		opSrm,
		opSx16r,
		opSrx16,
		opSpc,
		opAddx16,
		opSubx16,
		opInc16,
		opDec16,
		opBit,
		opShl,
		opZ801bop,
		opJcb
	} uopOpT;

	// Operand register
	typedef enum logic [4:0] {
		regNull,
		regA,
		regB,
		regC,
		regD,
		regE,
		regH,
		regL,
		regHl,
		regSp,
		regPc,
		regPch,
		regX8,
		regX16
	} uopRegT;

	typedef struct packed {
		uopCtlT ctl;
		uopOpT  op;
		uopRegT operand;
	} uopT;

	// Fetch request whose zFlag feeds the conditional ends
	typedef struct packed {
		opcodeT opcode;
		logic   zFlag;
	} opReqT;

	////////////////////////////////////////
	// Opcodes with their own flow
	////////////////////////////////////////

	localparam opcodeT OpNop      = 8'h00;
	localparam opcodeT OpLdBn     = 8'h06;
	localparam opcodeT OpLdCn     = 8'h0E;
	localparam opcodeT OpLdAn     = 8'h3E;
	localparam opcodeT OpJr       = 8'h18;
	localparam opcodeT OpJrNz     = 8'h20;
	localparam opcodeT OpJrZ      = 8'h28;
	localparam opcodeT OpIncB     = 8'h04;
	localparam opcodeT OpDecB     = 8'h05;
	localparam opcodeT OpAddB     = 8'h80;
	localparam opcodeT OpSubB     = 8'h90;
	localparam opcodeT OpPushBc   = 8'hC5;
	localparam opcodeT OpPopBc    = 8'hC1;
	localparam opcodeT OpCall     = 8'hCD;
	localparam opcodeT OpRet      = 8'hC9;
	localparam opcodeT OpRetZ     = 8'hC8;
	localparam opcodeT OpRetNz    = 8'hC0;
	localparam opcodeT OpCbPrefix = 8'hCB;

	// CB suffix bytes
	localparam opcodeT CbBit7H = 8'h7C;
	localparam opcodeT CbRlC   = 8'h11;

endpackage

// ==== opcodeDispatch.sv ====
`timescale 1ns/1ps

module opcodeDispatch import ucodePkg::*; (
	input  opcodeT  opcode,
	input  logic    cb,
	output flowIdxT flowIdx
);

	flowIdxT mainIdx;
	flowIdxT cbIdx;

	////////////////////////////////////////
	// Main opcode table
	////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			OpCbPrefix: mainIdx = 9'd1;
			OpJrNz:     mainIdx = 9'd5;
			OpLdCn:     mainIdx = 9'd11;
			OpLdAn:     mainIdx = 9'd14;
			OpCall:     mainIdx = 9'd17;
			OpLdBn:     mainIdx = 9'd28;
			OpPushBc:   mainIdx = 9'd31;
			OpPopBc:    mainIdx = 9'd38;
			OpJrZ:      mainIdx = 9'd44;
			OpJr:       mainIdx = 9'd50;
			OpSubB:     mainIdx = 9'd56;
			OpIncB:     mainIdx = 9'd59;
			OpNop:      mainIdx = 9'd60;
			OpAddB:     mainIdx = 9'd61;
			OpRet:      mainIdx = 9'd64;
			OpDecB:     mainIdx = 9'd75;
			OpRetZ:     mainIdx = 9'd77;
			OpRetNz:    mainIdx = 9'd86;
			// Anything else goes to the generic one byte flow
			default:    mainIdx = 9'd73;
		endcase
	end

	////////////////////////////////////////
	// CB suffix table
	////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			CbBit7H: cbIdx = 9'd4;
			CbRlC:   cbIdx = 9'd37;
			// Single word default at the bottom of the ROM
			default: cbIdx = 9'd0;
		endcase
	end

	// Sequencer says which table is live
	assign flowIdx = cb ? cbIdx : mainIdx;

endmodule

// ==== ucodeRom.sv ====
`timescale 1ns/1ps

module ucodeRom import ucodePkg::*; (
	input  flowIdxT addr,
	output uopT     uop
);

	always_comb
	begin
		case (addr)
			////////////////////////////////////////
			// CB prefix and its targets
			////////////////////////////////////////
			// CB default
			9'd0:  uop = '{ctlEofFu, opZ801bop, regA};
			// CB prefix handing over to the CB table
			9'd1:  uop = '{ctlInc, opSma, regPc};
			9'd2:  uop = '{ctlOp, opNop, regNull};
			9'd3:  uop = '{ctlInc, opJcb, regNull};
			// BIT 7,H
			9'd4:  uop = '{ctlEofFu, opBit, regH};
			////////////////////////////////////////
			// Loads, relative jumps and calls
			////////////////////////////////////////
			// JR NZ,n
			9'd5:  uop = '{ctlInc, opSma, regPc};
			9'd6:  uop = '{ctlOp, opNop, regNull};
			// Falls through on Z, otherwise x8 = MEM[pc]
			9'd7:  uop = '{ctlIncEofZ, opSrm, regX8};
			9'd8:  uop = '{ctlOp, opSx16r, regPc};
			9'd9:  uop = '{ctlOp, opAddx16, regX8};
			9'd10: uop = '{ctlEof, opSpc, regX16};
			// LD C,n
			9'd11: uop = '{ctlInc, opSma, regPc};
			9'd12: uop = '{ctlInc, opNop, regNull};
			9'd13: uop = '{ctlEof, opSrm, regC};
			// LD A,n
			9'd14: uop = '{ctlInc, opSma, regPc};
			9'd15: uop = '{ctlInc, opNop, regNull};
			9'd16: uop = '{ctlEof, opSrm, regA};
			// CALL nn
			9'd17: uop = '{ctlInc, opDec16, regSp};
			9'd18: uop = '{ctlInc, opSx16r, regHl};
			// Target address lands in HL
			9'd19: uop = '{ctlOp, opSrm, regL};
			9'd20: uop = '{ctlInc, opSrm, regH};
			9'd21: uop = '{ctlOp, opSma, regSp};
			9'd22: uop = '{ctlOp, opSmw, regPch};
			9'd23: uop = '{ctlOp, opDec16, regSp};
			9'd24: uop = '{ctlOp, opSmw, regPc};
			9'd25: uop = '{ctlOp, opSpc, regHl};
			9'd26: uop = '{ctlOp, opSrx16, regHl};
			9'd27: uop = '{ctlEof, opSma, regPc};
			// LD B,n
			9'd28: uop = '{ctlInc, opSma, regPc};
			9'd29: uop = '{ctlInc, opNop, regNull};
			9'd30: uop = '{ctlEof, opSrm, regB};
			////////////////////////////////////////
			// Stack and rotate
			////////////////////////////////////////
			// PUSH BC
			9'd31: uop = '{ctlOp, opDec16, regSp};
			9'd32: uop = '{ctlOp, opSma, regSp};
			9'd33: uop = '{ctlOp, opSmw, regB};
			9'd34: uop = '{ctlOp, opDec16, regSp};
			9'd35: uop = '{ctlOp, opSmw, regC};
			9'd36: uop = '{ctlIncEof, opSma, regPc};
			// RL C
			9'd37: uop = '{ctlEofFu, opShl, regC};
			// POP BC
			9'd38: uop = '{ctlOp, opSma, regSp};
			9'd39: uop = '{ctlOp, opInc16, regSp};
			9'd40: uop = '{ctlOp, opSrm, regC};
			9'd41: uop = '{ctlOp, opSrm, regB};
			9'd42: uop = '{ctlInc, opInc16, regSp};
			9'd43: uop = '{ctlEof, opSma, regPc};
			// JR Z,n
			9'd44: uop = '{ctlInc, opSma, regPc};
			9'd45: uop = '{ctlOp, opNop, regNull};
			9'd46: uop = '{ctlIncEofNz, opSrm, regX8};
			9'd47: uop = '{ctlOp, opSx16r, regPc};
			9'd48: uop = '{ctlOp, opAddx16, regX8};
			9'd49: uop = '{ctlEof, opSpc, regX16};
			// JR n
			9'd50: uop = '{ctlInc, opSma, regPc};
			9'd51: uop = '{ctlOp, opNop, regNull};
			9'd52: uop = '{ctlInc, opSrm, regX8};
			9'd53: uop = '{ctlOp, opSx16r, regPc};
			// Signed offset added to the saved pc
			9'd54: uop = '{ctlOp, opAddx16, regX8};
			9'd55: uop = '{ctlEof, opSpc, regX16};
			////////////////////////////////////////
			// ALU and single byte ops
			////////////////////////////////////////
			// SUB B
			9'd56: uop = '{ctlOp, opSx16r, regA};
			9'd57: uop = '{ctlUpdFlags, opSubx16, regB};
			9'd58: uop = '{ctlIncEof, opSrx16, regA};
			// INC B
			9'd59: uop = '{ctlIncEofFu, opInc16, regB};
			// NOP
			9'd60: uop = '{ctlIncEof, opNop, regNull};
			// ADD A,B
			9'd61: uop = '{ctlOp, opSx16r, regA};
			9'd62: uop = '{ctlUpdFlags, opAddx16, regB};
			9'd63: uop = '{ctlIncEof, opSrx16, regA};
			// RET
			9'd64: uop = '{ctlOp, opSma, regSp};
			9'd65: uop = '{ctlOp, opSx16r, regHl};
			9'd66: uop = '{ctlOp, opInc16, regSp};
			9'd67: uop = '{ctlOp, opSrm, regL};
			9'd68: uop = '{ctlOp, opSrm, regH};
			9'd69: uop = '{ctlOp, opSpc, regHl};
			9'd70: uop = '{ctlOp, opSrx16, regHl};
			9'd71: uop = '{ctlOp, opInc16, regSp};
			9'd72: uop = '{ctlEof, opSma, regPc};
			// Main default
			9'd73: uop = '{ctlUpdFlags, opZ801bop, regA};
			9'd74: uop = '{ctlIncEof, opNop, regNull};
			// DEC B
			9'd75: uop = '{ctlUpdFlags, opDec16, regB};
			9'd76: uop = '{ctlIncEof, opNop, regNull};
			////////////////////////////////////////
			// Conditional returns
			////////////////////////////////////////
			// RET Z with the test in its first word
			9'd77: uop = '{ctlIncEofNz, opSma, regSp};
			9'd78: uop = '{ctlOp, opSx16r, regHl};
			9'd79: uop = '{ctlOp, opInc16, regSp};
			9'd80: uop = '{ctlOp, opSrm, regL};
			9'd81: uop = '{ctlOp, opSrm, regH};
			9'd82: uop = '{ctlOp, opSpc, regHl};
			9'd83: uop = '{ctlOp, opSrx16, regHl};
			9'd84: uop = '{ctlOp, opInc16, regSp};
			9'd85: uop = '{ctlEof, opSma, regPc};
			// RET NZ
			9'd86: uop = '{ctlIncEofZ, opSma, regSp};
			9'd87: uop = '{ctlOp, opSx16r, regHl};
			9'd88: uop = '{ctlOp, opInc16, regSp};
			9'd89: uop = '{ctlOp, opSrm, regL};
			9'd90: uop = '{ctlOp, opSrm, regH};
			9'd91: uop = '{ctlOp, opSpc, regHl};
			9'd92: uop = '{ctlOp, opSrx16, regHl};
			9'd93: uop = '{ctlOp, opInc16, regSp};
			9'd94: uop = '{ctlEof, opSma, regPc};
			default: uop = '{ctlOp, opNop, regNull};
		endcase
	end

endmodule

// ==== ucodeSequencer.sv ====
`timescale 1ns/1ps

module ucodeSequencer import ucodePkg::*; (
	input  logic    clock,
	input  logic    rst,
	input  logic    opValid,
	input  opReqT   opReq,
	output logic    opReady,
	output opcodeT  dispOpcode,
	output logic    dispCb,
	input  flowIdxT flowIdx,
	output flowIdxT romAddr,
	input  uopT     romUop,
	output logic    uopValid,
	output uopT     uop,
	input  logic    uopReady
);

	typedef enum logic [1:0] {
		sIdle,
		sRun,
		sWaitCb
	} seqStateT;

	seqStateT state;
	flowIdxT  upc;
	uopT      uopQ;
	logic     zSaved;
	logic     accept;
	logic     xfer;
	logic     flowEnd;
	logic     loadNext;

	////////////////////////////////////////
	// Handshakes
	////////////////////////////////////////

	// Ready for a byte both before a flow and after the CB prefix
	assign opReady = (state == sIdle) || (state == sWaitCb);
	assign uopValid = (state == sRun);
	assign uop = uopQ;
	assign accept = opValid && opReady;
	assign xfer = uopValid && uopReady;

	// The request byte goes straight to the lookup
	assign dispOpcode = opReq.opcode;
	assign dispCb = (state == sWaitCb);

	////////////////////////////////////////
	// Flow control decode
	////////////////////////////////////////

	always_comb
	begin
		case (uopQ.ctl)
			ctlEof, ctlIncEof, ctlEofFu, ctlIncEofFu:
				flowEnd = 1'b1;
			ctlIncEofZ:
				flowEnd = zSaved;
			ctlIncEofNz:
				flowEnd = !zSaved;
			default:
				flowEnd = 1'b0;
		endcase
	end

	// Step on unless the word just sent ends or jumps out
	assign loadNext = xfer && !flowEnd && (uopQ.op != opJcb);

	// Start index while waiting, next word while running
	assign romAddr = (state == sRun) ? upc + flowIdxT'(1) : flowIdx;

	////////////////////////////////////////
	// State and micro-PC
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= sIdle;
			upc <= '0;
		end
		else
		begin
			case (state)
				sIdle, sWaitCb:
				begin
					if (accept)
					begin
						state <= sRun;
						upc <= flowIdx;
					end
				end
				sRun:
				begin
					if (xfer && flowEnd)
						state <= sIdle;
					else if (xfer && (uopQ.op == opJcb))
						state <= sWaitCb;
					else if (loadNext)
						upc <= romAddr;
				end
				default:
					state <= sIdle;
			endcase
		end
	end

	// Output word and flag copy
	always_ff @(posedge clock)
	begin
		if (accept || loadNext)
			uopQ <= romUop;
		// CB suffix keeps the flag of the prefix
		if (accept && (state == sIdle))
			zSaved <= opReq.zFlag;
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	aHoldUop: assert property (@(posedge clock) disable iff (rst)
		uopValid && !uopReady |=> uopValid && $stable(uop))
		else $error("uop changed under back-pressure");

	// Only a fetched address has to be a real ROM word
	aRomRange: assert property (@(posedge clock) disable iff (rst)
		(accept || loadNext) |-> (romAddr < RomDepth))
		else $error("romAddr %0d past the ROM", romAddr);

endmodule

// ==== ucodeTop.sv ====
`timescale 1ns/1ps

module ucodeTop import ucodePkg::*; (
	input  logic  clock,
	input  logic  rst,
	input  logic  opValid,
	input  opReqT opReq,
	output logic  opReady,
	output logic  uopValid,
	output uopT   uop,
	input  logic  uopReady
);

	opcodeT  dispOpcode;
	logic    dispCb;
	flowIdxT flowIdx;
	flowIdxT romAddr;
	uopT     romUop;

	opcodeDispatch i_dispatch (
		.opcode  (dispOpcode),
		.cb      (dispCb),
		.flowIdx (flowIdx)
	);

	ucodeRom i_rom (
		.addr (romAddr),
		.uop  (romUop)
	);

	ucodeSequencer i_seq (
		.clock      (clock),
		.rst        (rst),
		.opValid    (opValid),
		.opReq      (opReq),
		.opReady    (opReady),
		.dispOpcode (dispOpcode),
		.dispCb     (dispCb),
		.flowIdx    (flowIdx),
		.romAddr    (romAddr),
		.romUop     (romUop),
		.uopValid   (uopValid),
		.uop        (uop),
		.uopReady   (uopReady)
	);

endmodule

// ==== tb_ucodeTop.sv ====
`timescale 1ns/1ps

module tb_ucodeTop import ucodePkg::*; ();

	localparam int Timeout = 200;
	localparam int RandomRuns = 300;

	logic   clock;
	logic   rst;
	logic   opValid;
	opReqT  opReq;
	logic   opReady;
	logic   uopValid;
	uopT    uop;
	logic   uopReady;

	int seed;
	int errorCount;
	int timeoutCount;

	opcodeT keptOps [18] = '{OpNop, OpLdBn, OpLdCn, OpLdAn, OpJr, OpJrNz, OpJrZ, OpIncB,
		OpDecB, OpAddB, OpSubB, OpPushBc, OpPopBc, OpCall, OpRet, OpRetZ, OpRetNz, OpCbPrefix};

	ucodeTop i_dut (
		.clock    (clock),
		.rst      (rst),
		.opValid  (opValid),
		.opReq    (opReq),
		.opReady  (opReady),
		.uopValid (uopValid),
		.uop      (uop),
		.uopReady (uopReady)
	);

	always #5 clock = ~clock;

	////////////////////////////////////////
	// Flow model
	////////////////////////////////////////

	// Micro-op count of a main flow for a given zero flag
	function automatic int flowLength(input opcodeT code, input logic z);
		case (code)
			OpNop, OpIncB:               return 1;
			OpLdBn, OpLdCn, OpLdAn:      return 3;
			OpAddB, OpSubB, OpCbPrefix:  return 3;
			OpJr, OpPushBc, OpPopBc:     return 6;
			OpJrNz:                      return z ? 3 : 6;
			OpJrZ:                       return z ? 6 : 3;
			OpDecB:                      return 2;
			OpCall:                      return 11;
			OpRet:                       return 9;
			OpRetZ:                      return z ? 9 : 1;
			OpRetNz:                     return z ? 1 : 9;
			default:                     return 2;
		endcase
	endfunction

	function automatic logic isListed(input opcodeT code);
		foreach (keptOps[i])
			if (keptOps[i] == code)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic uopOpT cbOpFor(input opcodeT code);
		if (code == CbBit7H)
			return opBit;
		else if (code == CbRlC)
			return opShl;
		else
			return opZ801bop;
	endfunction

	// Whether a word closes its flow under the given flag
	function automatic logic endsFlow(input uopT u, input logic z);
		case (u.ctl)
			ctlEof, ctlIncEof, ctlEofFu, ctlIncEofFu: return 1'b1;
			ctlIncEofZ:                               return z;
			ctlIncEofNz:                              return !z;
			default:                                  return 1'b0;
		endcase
	endfunction

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			errorCount++;
			$display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic nextCycle();
		@(posedge clock);
		#1;
	endtask

	// One opcode byte through the DUT, counting transferred words
	task automatic runFlow(input opcodeT code, input logic z, input logic isCb);
		int expLen;
		int count;
		int waitCycles;
		logic isPrefix;
		logic heldValid;
		logic done;
		uopT heldUop;
		logic [31:0] rnd;
		isPrefix = !isCb && (code == OpCbPrefix);
		expLen = isCb ? 1 : flowLength(code, z);
		rnd = $random(seed);
		repeat (rnd[1:0])
			nextCycle();
		waitCycles = 0;
		while (!opReady && timeoutCount == 0)
		begin
			nextCycle();
			waitCycles++;
			if (waitCycles >= Timeout)
			begin
				$display("timeout: opReady stayed low for %0d cycles", Timeout);
				timeoutCount++;
			end
		end
		if (timeoutCount == 0)
		begin
			opValid = 1'b1;
			opReq.opcode = code;
			opReq.zFlag = z;
			nextCycle();
			opValid = 1'b0;
			checkValue("uopValid", 32'(uopValid), 32'd1);
			checkValue("opReady", 32'(opReady), 32'd0);
			count = 0;
			waitCycles = 0;
			heldValid = 1'b0;
			done = 1'b0;
			while (!done && timeoutCount == 0)
			begin
				rnd = $random(seed);
				uopReady = (rnd[1:0] != 2'b00);
				if (!uopValid)
					done = 1'b1;
				else
				begin
					// No new byte is taken while a flow is running
					checkValue("opReady", 32'(opReady), 32'd0);
					if (heldValid)
						checkValue("uop held", 32'(uop), 32'(heldUop));
					if (uopReady)
					begin
						// Word transfers on the coming edge
						heldValid = 1'b0;
						checkValue("uop flow end", 32'(endsFlow(uop, z)),
							32'(!isPrefix && (count == expLen - 1)));
						if (isCb)
						begin
							checkValue("uop.ctl", 32'(uop.ctl), 32'(ctlEofFu));
							checkValue("uop.op", 32'(uop.op), 32'(cbOpFor(code)));
						end
						else if (isPrefix)
							checkValue("uop.op opJcb", 32'(uop.op == opJcb),
								32'(count == expLen - 1));
						else if (!isListed(code) && count == 0)
							checkValue("uop.op", 32'(uop.op), 32'(opZ801bop));
						count++;
					end
					else
					begin
						heldValid = 1'b1;
						heldUop = uop;
					end
					nextCycle();
					waitCycles++;
					if (waitCycles >= Timeout)
					begin
						$display("timeout: flow for opcode %0h did not finish", code);
						timeoutCount++;
					end
				end
			end
			checkValue("uop count", 32'(count), 32'(expLen));
			checkValue("opReady", 32'(opReady), 32'd1);
		end
	endtask

	// A main opcode, plus its suffix byte after the CB prefix
	task automatic runInstruction(input opcodeT code, input logic z, input opcodeT suffix);
		runFlow(code, z, 1'b0);
		if (code == OpCbPrefix && timeoutCount == 0)
			runFlow(suffix, !z, 1'b1);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		logic [31:0] rnd;
		opcodeT code;
		opcodeT suffix;
		int run;
		seed = 32'h74a1_2ad5;
		errorCount = 0;
		timeoutCount = 0;
		clock = 1'b0;
		rst = 1'b1;
		opValid = 1'b0;
		opReq = '0;
		uopReady = 1'b0;
		repeat (4)
			@(posedge clock);
		#1;
		rst = 1'b0;
		checkValue("opReady", 32'(opReady), 32'd1);
		checkValue("uopValid", 32'(uopValid), 32'd0);

		// Every kept opcode under both flag values
		foreach (keptOps[i])
		begin
			runInstruction(keptOps[i], 1'b0, CbBit7H);
			runInstruction(keptOps[i], 1'b1, CbRlC);
		end
		runInstruction(8'hD3, 1'b0, 8'h00);
		runInstruction(OpCbPrefix, 1'b1, 8'h40);

		run = 0;
		while (run < RandomRuns && timeoutCount == 0)
		begin
			rnd = $random(seed);
			if (rnd[2:0] != 3'd0)
				code = keptOps[int'(rnd[15:8]) % 18];
			else
				code = rnd[23:16];
			case (rnd[26:25])
				2'd0:    suffix = CbBit7H;
				2'd1:    suffix = CbRlC;
				default: suffix = rnd[31:24];
			endcase
			runInstruction(code, rnd[4], suffix);
			run++;
		end

		$display("errors: %0d, timeouts: %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
ucodePkg.sv
opcodeDispatch.sv
ucodeRom.sv
ucodeSequencer.sv
ucodeTop.sv
tb_ucodeTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the microcode front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_ucodeTop \
	-f filelist.f -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "test passed" sim.log && exit 0 || exit 1
